// ==== flist.f ====
+incdir+include
source/cpu_mem_pkg.sv
source/board_io_pkg.sv
source/rx_queue.sv
source/bus_sequencer.sv
source/ram_uart.sv
tb/board_models.sv
tb/tb_ram_uart.sv

// ==== include/mem_uart_consts.svh ====
`ifndef MEM_UART_CONSTS_SVH
`define MEM_UART_CONSTS_SVH

// Bus widths
`define ADDR_W 18
`define DATA_W 16
`define ACT_W 8

// Decoded UART addresses, everything else goes to SRAM
`define UART_DATA_ADDR 18'h0BF00
`define UART_STAT_ADDR 18'h0BF01

// Receive queue holds 2**RXQ_DEPTH_LOG2 words
`define RXQ_DEPTH_LOG2 4

// One bus step every 2**STEP_DIV_W clocks
`define STEP_DIV_W 2

// Steps allowed on tbre/tsre before the write is sent again
`define TX_RETRY_LIMIT 64

`endif

// ==== source/board_io_pkg.sv ====
package board_io_pkg;

	// SRAM chip strobes, all active low
	typedef struct packed {
		logic en_n;
		logic oe_n;
		logic we_n;
	} sram_ctrl_t;

	// UART chip read and write strobes, active low
	typedef struct packed {
		logic rdn;
		logic wrn;
	} uart_ctrl_t;

	// Status pins from the UART chip
	typedef struct packed {
		logic data_ready;
		logic tbre;
		logic tsre;
	} uart_stat_t;

	// Shared bus sequencer states
	typedef enum logic [4:0] {
		IDLE,
		RX_CHECK,
		RX_STROBE,
		RX_CAPTURE,
		TX_SETUP,
		TX_STROBE_LO,
		TX_STROBE_HI,
		TX_WAIT_TBRE,
		TX_WAIT_TSRE,
		RAM_RD_EN,
		RAM_RD_OE,
		RAM_RD_CAPTURE,
		RAM_WR_EN,
		RAM_WR_STROBE,
		RAM_WR_END,
		QUEUE_POP,
		STAT_READ
	} bus_state_e;

endpackage

// ==== source/bus_sequencer.sv ====
`include "mem_uart_consts.svh"

module bus_sequencer
	import cpu_mem_pkg::*;
	import board_io_pkg::*;
(
	input  logic               clk,
	input  logic               rst,

	input  logic               need_to_work,
	input  mem_req_t           req,
	output mem_resp_t          resp,

	input  uart_stat_t         uart_stat,
	input  logic [`DATA_W-1:0] bus_rdata,
	output logic [`ADDR_W-1:0] bus_addr,
	output logic [`DATA_W-1:0] bus_wdata,
	output logic               bus_drive,
	output sram_ctrl_t         sram,
	output uart_ctrl_t         uart,

	input  logic [`DATA_W-1:0] q_head,
	input  logic               q_empty,
	input  logic               q_full,
	output logic               q_push,
	output logic [`DATA_W-1:0] q_push_data,
	output logic               q_pop
);

	localparam int RETRY_W = $clog2(`TX_RETRY_LIMIT + 1);
	localparam logic [RETRY_W-1:0] RETRY_MAX = RETRY_W'(`TX_RETRY_LIMIT);

	logic [`STEP_DIV_W-1:0] step_cnt;
	logic                   step;

	bus_state_e             state;
	bus_state_e             req_state;

	logic [`ACT_W-1:0]      done_tag;
	logic                   done_flag;
	logic                   err_q;
	logic [`DATA_W-1:0]     rdata_q;

	logic                   pending;
	logic                   accept;
	logic                   is_uart_data;
	logic                   is_uart_stat;
	logic                   op_rd;
	logic                   op_err;
	logic                   pop_wait;
	logic [RETRY_W-1:0]     retry_cnt;
	logic [`DATA_W-1:0]     stat_word;

	//////////////////////////////////////////////////////////////////////
	// Step divider
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			step_cnt <= '0;
		end
		else begin
			step_cnt <= step_cnt + 1'b1;
		end
	end

	assign step = (step_cnt == '0);

	//////////////////////////////////////////////////////////////////////
	// Request decode
	//////////////////////////////////////////////////////////////////////

	// New request when the tag moved away from the last completed one
	assign pending = need_to_work && (req.act != done_tag);

	assign is_uart_data = (req.addr == `UART_DATA_ADDR);
	assign is_uart_stat = (req.addr == `UART_STAT_ADDR);

	// Receive has priority over the processor
	assign accept = step && (state == IDLE) && !uart_stat.data_ready && pending;

	// Invalid requests take the one-step status path
	always_comb begin
		if (!req.rd && !req.wr) begin
			req_state = STAT_READ;
		end
		else if (is_uart_stat) begin
			req_state = STAT_READ;
		end
		else if (is_uart_data) begin
			req_state = req.rd ? QUEUE_POP : TX_SETUP;
		end
		else begin
			req_state = req.rd ? RAM_RD_EN : RAM_WR_EN;
		end
	end

	assign stat_word = {{(`DATA_W-3){1'b0}}, q_full,
	                    uart_stat.tbre & uart_stat.tsre, ~q_empty};

	// Latched at accept, held for the whole bus cycle
	always_ff @(posedge clk) begin
		if (accept) begin
			bus_addr  <= req.addr;
			bus_wdata <= req.wdata;
			op_rd     <= req.rd;
			op_err    <= !req.rd && !req.wr;
		end
		if (step && state == RX_CAPTURE) begin
			q_push_data <= bus_rdata;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bus state machine
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= IDLE;
			sram      <= '1;
			uart      <= '1;
			bus_drive <= 1'b0;
			done_flag <= 1'b0;
			done_tag  <= '0;
			err_q     <= 1'b0;
			rdata_q   <= '0;
			q_push    <= 1'b0;
			q_pop     <= 1'b0;
			pop_wait  <= 1'b0;
			retry_cnt <= '0;
		end
		else begin
			// Queue strobes last one clock
			q_push <= 1'b0;
			q_pop  <= 1'b0;
			if (step) begin
				case (state)
					IDLE: begin
						sram      <= '1;
						uart      <= '1;
						bus_drive <= 1'b0;
						if (uart_stat.data_ready) begin
							state <= RX_CHECK;
						end
						else if (pending) begin
							done_flag <= 1'b0;
							state     <= req_state;
						end
					end

					// Receive one byte into the queue
					RX_CHECK: begin
						if (uart_stat.data_ready) begin
							uart.rdn <= 1'b0;
							state    <= RX_STROBE;
						end
						else begin
							state <= IDLE;
						end
					end
					RX_STROBE: begin
						state <= RX_CAPTURE;
					end
					RX_CAPTURE: begin
						q_push   <= 1'b1;
						uart.rdn <= 1'b1;
						state    <= IDLE;
					end

					// Transmit, then wait for the chip to drain
					TX_SETUP: begin
						bus_drive <= 1'b1;
						uart.wrn  <= 1'b1;
						retry_cnt <= '0;
						state     <= TX_STROBE_LO;
					end
					TX_STROBE_LO: begin
						uart.wrn <= 1'b0;
						state    <= TX_STROBE_HI;
					end
					TX_STROBE_HI: begin
						uart.wrn <= 1'b1;
						state    <= TX_WAIT_TBRE;
					end
					TX_WAIT_TBRE: begin
						if (uart_stat.tbre) begin
							state <= TX_WAIT_TSRE;
						end
						else if (retry_cnt == RETRY_MAX) begin
							state <= TX_SETUP;
						end
						else begin
							retry_cnt <= retry_cnt + 1'b1;
						end
					end
					TX_WAIT_TSRE: begin
						if (uart_stat.tsre) begin
							err_q     <= 1'b0;
							done_flag <= 1'b1;
							done_tag  <= req.act;
							state     <= IDLE;
						end
						else if (retry_cnt == RETRY_MAX) begin
							state <= TX_SETUP;
						end
						else begin
							retry_cnt <= retry_cnt + 1'b1;
						end
					end

					// SRAM read
					RAM_RD_EN: begin
						sram.en_n <= 1'b0;
						state     <= RAM_RD_OE;
					end
					RAM_RD_OE: begin
						sram.oe_n <= 1'b0;
						state     <= RAM_RD_CAPTURE;
					end
					RAM_RD_CAPTURE: begin
						rdata_q   <= bus_rdata;
						sram.en_n <= 1'b1;
						sram.oe_n <= 1'b1;
						err_q     <= 1'b0;
						done_flag <= 1'b1;
						done_tag  <= req.act;
						state     <= IDLE;
					end

					// SRAM write, bus stays driven until the next IDLE step
					RAM_WR_EN: begin
						sram.en_n <= 1'b0;
						bus_drive <= 1'b1;
						state     <= RAM_WR_STROBE;
					end
					RAM_WR_STROBE: begin
						sram.we_n <= 1'b0;
						state     <= RAM_WR_END;
					end
					RAM_WR_END: begin
						sram.we_n <= 1'b1;
						sram.en_n <= 1'b1;
						err_q     <= 1'b0;
						done_flag <= 1'b1;
						done_tag  <= req.act;
						state     <= IDLE;
					end

					// Head is taken on the first step, done on the second
					QUEUE_POP: begin
						if (!pop_wait) begin
							rdata_q  <= q_empty ? '0 : q_head;
							q_pop    <= !q_empty;
							pop_wait <= 1'b1;
						end
						else begin
							pop_wait  <= 1'b0;
							err_q     <= 1'b0;
							done_flag <= 1'b1;
							done_tag  <= req.act;
							state     <= IDLE;
						end
					end

					STAT_READ: begin
						if (op_rd) begin
							rdata_q <= stat_word;
						end
						err_q     <= op_err;
						done_flag <= 1'b1;
						done_tag  <= req.act;
						state     <= IDLE;
					end

					default: begin
						state <= IDLE;
					end
				endcase
			end
		end
	end

	// Done drops as soon as a new tag shows up
	always_comb begin
		resp.rdata = rdata_q;
		resp.done  = done_flag && (req.act == done_tag);
		resp.err   = err_q;
	end

endmodule

// ==== source/cpu_mem_pkg.sv ====
`include "mem_uart_consts.svh"

package cpu_mem_pkg;

	// Request from the processor side
	typedef struct packed {
		logic [`ADDR_W-1:0] addr;
		logic [`DATA_W-1:0] wdata;
		logic               rd;
		logic               wr;
		logic [`ACT_W-1:0]  act;
	} mem_req_t;

	// Completion back to the processor
	typedef struct packed {
		logic [`DATA_W-1:0] rdata;
		logic               done;
		logic               err;
	} mem_resp_t;

	// rd wins over wr
	// a request with neither flag completes with err

endpackage

// ==== source/ram_uart.sv ====
`include "mem_uart_consts.svh"

module ram_uart
	import cpu_mem_pkg::*;
	import board_io_pkg::*;
(
	input  logic               clk,
	input  logic               rst,

	input  logic               need_to_work,
	input  mem_req_t           req,
	output mem_resp_t          resp,

	input  uart_stat_t         uart_stat,
	output logic [`ADDR_W-1:0] bus_addr,
	output sram_ctrl_t         sram,
	output uart_ctrl_t         uart,
	inout  wire  [`DATA_W-1:0] bus_data
);

	logic [`DATA_W-1:0] bus_wdata;
	logic               bus_drive;

	logic [`DATA_W-1:0] q_head;
	logic               q_empty;
	logic               q_full;
	logic               q_push;
	logic [`DATA_W-1:0] q_push_data;
	logic               q_pop;

	// Shared data bus, released whenever a chip may drive it
	assign bus_data = bus_drive ? bus_wdata : {`DATA_W{1'bz}};

	bus_sequencer i_seq (
		.clk          (clk),
		.rst          (rst),
		.need_to_work (need_to_work),
		.req          (req),
		.resp         (resp),
		.uart_stat    (uart_stat),
		.bus_rdata    (bus_data),
		.bus_addr     (bus_addr),
		.bus_wdata    (bus_wdata),
		.bus_drive    (bus_drive),
		.sram         (sram),
		.uart         (uart),
		.q_head       (q_head),
		.q_empty      (q_empty),
		.q_full       (q_full),
		.q_push       (q_push),
		.q_push_data  (q_push_data),
		.q_pop        (q_pop)
	);

	rx_queue i_rxq (
		.clk       (clk),
		.rst       (rst),
		.push      (q_push),
		.push_data (q_push_data),
		.pop       (q_pop),
		.head      (q_head),
		.empty     (q_empty),
		.full      (q_full)
	);

endmodule

// ==== source/rx_queue.sv ====
`include "mem_uart_consts.svh"

module rx_queue (
	input  logic               clk,
	input  logic               rst,
	input  logic               push,
	input  logic [`DATA_W-1:0] push_data,
	input  logic               pop,
	output logic [`DATA_W-1:0] head,
	output logic               empty,
	output logic               full
);

	localparam int PTR_W = `RXQ_DEPTH_LOG2;
	localparam int DEPTH = 1 << PTR_W;

	logic [`DATA_W-1:0] mem [DEPTH];

	// Extra top bit tells full from empty
	logic [PTR_W:0] front;
	logic [PTR_W:0] tail;

	logic do_push;
	logic do_pop;

	assign empty = (front == tail);
	assign full  = (front[PTR_W] != tail[PTR_W]) &&
	               (front[PTR_W-1:0] == tail[PTR_W-1:0]);

	// Push on full and pop on empty are ignored
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign head = mem[front[PTR_W-1:0]];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			front <= '0;
			tail  <= '0;
		end
		else begin
			if (do_push) begin
				tail <= tail + 1'b1;
			end
			if (do_pop) begin
				front <= front + 1'b1;
			end
		end
	end

	// Storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[tail[PTR_W-1:0]] <= push_data;
		end
	end

endmodule

// ==== tb/board_models.sv ====
`include "mem_uart_consts.svh"

module board_models
	import board_io_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic [`ADDR_W-1:0] bus_addr,
	input  sram_ctrl_t         sram,
	input  uart_ctrl_t         uart,
	output uart_stat_t         uart_stat,
	inout  wire  [`DATA_W-1:0] bus_data
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [`DATA_W-1:0] ram [0:(1<<`ADDR_W)-1];

	// Bytes waiting to be received, pushed in by the testbench top
	logic [7:0]         rx_script[$];
	logic [`DATA_W-1:0] rx_word = '0;
	int                 rx_gap = 0;
	logic               rdn_q = 1'b1;

	// Words seen on the transmit strobe, oldest first
	logic [`DATA_W-1:0] tx_log[$];
	int                 tbre_cnt = 0;
	int                 tsre_cnt = 0;
	logic               wrn_q = 1'b1;

	// data_ready low, tbre and tsre high
	uart_stat_t         stat_q = 3'b011;

	assign uart_stat = stat_q;

	// Both chips share the bus with the DUT
	assign bus_data = (!sram.en_n && !sram.oe_n && sram.we_n) ?
	                  ram[bus_addr] : {`DATA_W{1'bz}};
	assign bus_data = !uart.rdn ? rx_word : {`DATA_W{1'bz}};

	initial begin
		for (int a = 0; a < (1 << `ADDR_W); a++) begin
			ram[a] = 16'(a) ^ 16'(a >> 16) ^ 16'h5A5A;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// SRAM chip
	//////////////////////////////////////////////////////////////////////

	// Word is stored as the write strobe ends
	always @(posedge sram.we_n) begin
		if (rst) begin
			ram[bus_addr] <= bus_data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// UART chip
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		int d_tbre;
		int d_tsre;
		d_tbre = int'(bus_data % 16'd31);
		d_tsre = int'(bus_data[15:8] % 8'd31);
		if (d_tsre < d_tbre) begin
			d_tsre = d_tbre;
		end
		rdn_q <= uart.rdn;
		wrn_q <= uart.wrn;

		// Receive side, data_ready released once rdn is back high
		if (stat_q.data_ready && uart.rdn && !rdn_q) begin
			stat_q.data_ready <= 1'b0;
			rx_gap            <= 2;
		end
		else if (rx_gap != 0) begin
			rx_gap <= rx_gap - 1;
		end
		else if (!stat_q.data_ready && rx_script.size() != 0) begin
			rx_word           <= {8'h00, rx_script.pop_front()};
			stat_q.data_ready <= 1'b1;
		end

		// Transmit side, busy for a while after each strobe
		if (!uart.wrn && wrn_q) begin
			tx_log.push_back(bus_data);
			tbre_cnt    <= d_tbre;
			tsre_cnt    <= d_tsre;
			stat_q.tbre <= 1'b0;
			stat_q.tsre <= 1'b0;
		end
		else begin
			if (tbre_cnt != 0) begin
				tbre_cnt <= tbre_cnt - 1;
			end
			else begin
				stat_q.tbre <= 1'b1;
			end
			if (tsre_cnt != 0) begin
				tsre_cnt <= tsre_cnt - 1;
			end
			else begin
				stat_q.tsre <= 1'b1;
			end
		end
	end

endmodule

// ==== tb/tb_ram_uart.sv ====
`include "mem_uart_consts.svh"

module tb_ram_uart
	import cpu_mem_pkg::*;
	import board_io_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CLKS = 2000;
	localparam int STEP_CLKS    = 1 << `STEP_DIV_W;
	localparam int RXQ_DEPTH    = 1 << `RXQ_DEPTH_LOG2;

	logic               clk;
	logic               rst;
	logic               need_to_work;
	mem_req_t           req;
	mem_resp_t          resp;
	uart_stat_t         uart_stat;
	logic [`ADDR_W-1:0] bus_addr;
	sram_ctrl_t         sram;
	uart_ctrl_t         uart;
	wire  [`DATA_W-1:0] bus_data;

	logic [31:0]        lcg_state = 32'd10;
	int                 cyc;
	int                 tx_count = 0;

	// Reference model state
	logic [`DATA_W-1:0] shadow [0:(1<<`ADDR_W)-1];
	logic [`ADDR_W-1:0] written[$];
	logic [`DATA_W-1:0] exp_rx[$];

	ram_uart i_dut (
		.clk          (clk),
		.rst          (rst),
		.need_to_work (need_to_work),
		.req          (req),
		.resp         (resp),
		.uart_stat    (uart_stat),
		.bus_addr     (bus_addr),
		.sram         (sram),
		.uart         (uart),
		.bus_data     (bus_data)
	);

	board_models i_models (
		.clk       (clk),
		.rst       (rst),
		.bus_addr  (bus_addr),
		.sram      (sram),
		.uart      (uart),
		.uart_stat (uart_stat),
		.bus_data  (bus_data)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Rising edges since reset release
	// Bus steps fall on edges 1, 5, 9 and so on
	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			cyc <= 0;
		end
		else begin
			cyc <= cyc + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 8;
	endfunction

	function automatic logic [`ADDR_W-1:0] random_sram_addr();
		logic [`ADDR_W-1:0] a;
		a = `ADDR_W'(next_rand());
		if (a == `UART_DATA_ADDR || a == `UART_STAT_ADDR) begin
			a[`ADDR_W-1] = ~a[`ADDR_W-1];
		end
		return a;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
			$display("TB FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string what);
		$display("Error at t=%0t: %s", $time, what);
		$display("TB FAILED");
		$fatal(1, "%s", what);
	endtask

	task automatic wait_done(output int done_cyc);
		int n;
		n = 0;
		while (resp.done !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT_CLKS) begin
				abort_run("resp.done did not rise within the timeout");
			end
		end
		done_cyc = cyc;
	endtask

	// Model only changes data_ready on falling edges
	task automatic wait_rx_drained();
		int n;
		n = 0;
		while (i_models.rx_script.size() != 0 || uart_stat.data_ready !== 1'b0) begin
			@(posedge clk);
			n++;
			if (n > TIMEOUT_CLKS) begin
				abort_run("the DUT did not take the received bytes within the timeout");
			end
		end
	endtask

	// steps of zero skips the latency check
	task automatic run_req(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] wdata,
			input logic rd, input logic wr, input int steps, output mem_resp_t got);
		int start_cyc;
		int accept_cyc;
		int done_cyc;
		@(negedge clk);
		if (req.act != '0) begin
			check_value("resp.done", resp.done, 1'b1);
		end
		req.addr     = addr;
		req.wdata    = wdata;
		req.rd       = rd;
		req.wr       = wr;
		req.act      = req.act + 1'b1;
		need_to_work = 1'b1;
		start_cyc    = cyc;
		#1;
		check_value("resp.done", resp.done, 1'b0);
		wait_done(done_cyc);
		if (steps > 0) begin
			accept_cyc = start_cyc + 1 + ((STEP_CLKS - start_cyc % STEP_CLKS) % STEP_CLKS);
			check_value("resp.done latency", done_cyc - accept_cyc, steps * STEP_CLKS);
		end
		got = resp;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Operations with expected results
	//////////////////////////////////////////////////////////////////////

	task automatic sram_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
		mem_resp_t got;
		run_req(addr, data, 1'b0, 1'b1, 3, got);
		check_value("resp.err", got.err, 1'b0);
		check_value("bus_addr", bus_addr, addr);
		shadow[addr] = data;
		written.push_back(addr);
	endtask

	task automatic sram_read(input logic [`ADDR_W-1:0] addr);
		mem_resp_t got;
		run_req(addr, `DATA_W'(next_rand()), 1'b1, 1'b0, 3, got);
		check_value("resp.err", got.err, 1'b0);
		check_value("bus_addr", bus_addr, addr);
		check_value("resp.rdata", got.rdata, shadow[addr]);
	endtask

	task automatic uart_send(input logic [`DATA_W-1:0] data);
		mem_resp_t got;
		run_req(`UART_DATA_ADDR, data, 1'b0, 1'b1, 0, got);
		tx_count++;
		check_value("resp.err", got.err, 1'b0);
		check_value("uart_stat.tbre", uart_stat.tbre, 1'b1);
		check_value("uart_stat.tsre", uart_stat.tsre, 1'b1);
		check_value("tx word count", i_models.tx_log.size(), tx_count);
		check_value("tx word", i_models.tx_log[tx_count-1], data);
	endtask

	task automatic uart_pop();
		mem_resp_t          got;
		logic [`DATA_W-1:0] exp;
		exp = '0;
		if (exp_rx.size() != 0) begin
			exp = exp_rx.pop_front();
		end
		run_req(`UART_DATA_ADDR, '0, 1'b1, 1'b0, 2, got);
		check_value("resp.err", got.err, 1'b0);
		check_value("resp.rdata", got.rdata, exp);
	endtask

	task automatic stat_read();
		mem_resp_t          got;
		logic [`DATA_W-1:0] exp;
		exp = {{(`DATA_W-3){1'b0}}, exp_rx.size() == RXQ_DEPTH, 1'b1, exp_rx.size() != 0};
		run_req(`UART_STAT_ADDR, '0, 1'b1, 1'b0, 1, got);
		check_value("resp.err", got.err, 1'b0);
		check_value("resp.rdata", got.rdata, exp);
	endtask

	task automatic bad_req();
		mem_resp_t got;
		run_req(random_sram_addr(), '0, 1'b0, 1'b0, 1, got);
		check_value("resp.err", got.err, 1'b1);
	endtask

	// A full queue drops further bytes
	task automatic inject_bytes(input int n);
		logic [7:0] b;
		for (int i = 0; i < n; i++) begin
			b = 8'(next_rand());
			i_models.rx_script.push_back(b);
			if (exp_rx.size() < RXQ_DEPTH) begin
				exp_rx.push_back({8'h00, b});
			end
		end
		wait_rx_drained();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		int kind;
		rst          = 1'b0;
		need_to_work = 1'b0;
		req          = '0;
		repeat (5) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		check_value("sram.en_n", sram.en_n, 1'b1);
		check_value("sram.oe_n", sram.oe_n, 1'b1);
		check_value("sram.we_n", sram.we_n, 1'b1);
		check_value("uart.rdn", uart.rdn, 1'b1);
		check_value("uart.wrn", uart.wrn, 1'b1);
		check_value("resp.done", resp.done, 1'b0);

		// Random mix of all request kinds and received bytes
		for (int i = 0; i < 160; i++) begin
			kind = next_rand() % 8;
			case (kind)
				0, 1: sram_write(random_sram_addr(), `DATA_W'(next_rand()));
				2, 3: begin
					if (written.size() == 0) begin
						sram_write(random_sram_addr(), `DATA_W'(next_rand()));
					end
					else begin
						sram_read(written[next_rand() % written.size()]);
					end
				end
				4: uart_send(`DATA_W'(next_rand()));
				5: uart_pop();
				6: inject_bytes(1 + next_rand() % 3);
				default: begin
					if (next_rand() % 4 == 0) begin
						bad_req();
					end
					else begin
						stat_read();
					end
				end
			endcase
		end

		// Overfill the queue and drain it past empty
		inject_bytes(RXQ_DEPTH - exp_rx.size() + 2);
		stat_read();
		while (exp_rx.size() != 0) begin
			uart_pop();
		end
		uart_pop();
		stat_read();
		bad_req();
		sram_read(written[0]);

		$display("TB PASSED");
		$finish;
	end

endmodule
